//--- Makefile
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := decode_stage_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := ** FAIL **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# A nonzero exit of the simulator also counts as a failure in the log
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/decode_if.sv
`timescale 1ns/100ps

interface decode_if;

    rv_pkg::word_t     instr;       // Word under decode
    rv_pkg::op_e       op;
    rv_pkg::format_e   fmt;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::reg_addr_t rd;
    logic              is_store;
    logic              is_mem;      // Op goes to the memory unit

    modport producer (
        output instr, op, fmt, rs1, rs2, rd, is_store, is_mem
    );
    modport imm_view   (input instr, fmt);
    modport lock_view  (input rs1, rs2, rd, is_store, is_mem);
    modport issue_view (input op, fmt);

endinterface

//--- rtl/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              stall_i,
    input  rv_pkg::word_t     instruction_i,
    input  rv_pkg::word_t     pc_i,
    input  rv_pkg::tag_t      tag_i,
    input  rv_pkg::word_t     rs1_data_i,     // Register file read data
    input  rv_pkg::word_t     rs2_data_i,
    output rv_pkg::reg_addr_t rs1_o,          // Register file read addresses
    output rv_pkg::reg_addr_t rs2_o,
    output rv_pkg::reg_addr_t rd_o,
    output rv_pkg::word_t     operand1_o,
    output rv_pkg::word_t     operand2_o,
    output rv_pkg::word_t     operand3_o,
    output rv_pkg::word_t     pc_o,
    output rv_pkg::tag_t      tag_o,
    output rv_pkg::op_e       op_o,
    output logic              hazard_o,
    output logic              exception_o
);
    import rv_pkg::*;

    word_t cur_instr;
    word_t imm;
    logic  hazard;

    decode_if dec_bus ();

    instr_classifier i_instr_classifier (
        .cur_instr_i (cur_instr),
        .dec         (dec_bus.producer)
    );

    imm_gen i_imm_gen (
        .dec   (dec_bus.imm_view),
        .imm_o (imm)
    );

    reg_lock_queue i_reg_lock_queue (
        .clk      (clk),
        .reset    (reset),
        .stall_i  (stall_i),
        .dec      (dec_bus.lock_view),
        .hazard_o (hazard),
        .rd_o     (rd_o)
    );

    operand_issue i_operand_issue (
        .clk           (clk),
        .reset         (reset),
        .stall_i       (stall_i),
        .hazard_i      (hazard),
        .instruction_i (instruction_i),
        .pc_i          (pc_i),
        .tag_i         (tag_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .imm_i         (imm),
        .dec           (dec_bus.issue_view),
        .cur_instr_o   (cur_instr),
        .operand1_o    (operand1_o),
        .operand2_o    (operand2_o),
        .operand3_o    (operand3_o),
        .pc_o          (pc_o),
        .tag_o         (tag_o),
        .op_o          (op_o),
        .exception_o   (exception_o)
    );

    assign rs1_o    = dec_bus.rs1;      // Same cycle as the word
    assign rs2_o    = dec_bus.rs2;
    assign hazard_o = hazard;

endmodule

//--- rtl/imm_gen.sv
`timescale 1ns/100ps

module imm_gen (
    decode_if.imm_view    dec,
    output rv_pkg::word_t imm_o
);
    import rv_pkg::*;

    word_t ins;

    assign ins = dec.instr;

    always_comb begin
        case (dec.fmt)
            I_TYPE: begin
                imm_o = {{20{ins[31]}}, ins[31:20]};
            end
            S_TYPE: begin
                imm_o = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            end
            B_TYPE: begin
                imm_o = {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                         ins[11:8], 1'b0};                  // Halfword offset
            end
            U_TYPE: begin
                imm_o = {ins[31:12], 12'b0};
            end
            J_TYPE: begin
                imm_o = {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                         ins[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;                                 // R_TYPE has none
            end
        endcase
    end

endmodule

//--- rtl/instr_classifier.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module instr_classifier (
    input  rv_pkg::word_t cur_instr_i,      // Fresh or replayed word
    decode_if.producer    dec
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    op_e        op;
    format_e    fmt;

    assign opcode = cur_instr_i[6:0];
    assign funct3 = cur_instr_i[14:12];
    assign funct7 = cur_instr_i[31:25];

    ////////////////////////////////////////////////////////////
    // Operation
    ////////////////////////////////////////////////////////////

    always_comb begin
        op = INVALID;
        if (cur_instr_i == `NOP_WORD) begin
            op = NOP;                                       // Caught before ADDI
        end else begin
            case (opcode)
                `OPC_LUI:      op = LUI;
                `OPC_AUIPC:    op = ADD;                    // PC plus upper immediate
                `OPC_JAL:      op = JAL;
                `OPC_JALR:     op = (funct3 == `F3_JALR) ? JALR : INVALID;
                `OPC_MISC_MEM: op = (funct3 == `F3_FENCE) ? NOP : INVALID;
                `OPC_BRANCH: begin
                    case (funct3)
                        `F3_BEQ:  op = BEQ;
                        `F3_BNE:  op = BNE;
                        `F3_BLT:  op = BLT;
                        `F3_BGE:  op = BGE;
                        `F3_BLTU: op = BLTU;
                        `F3_BGEU: op = BGEU;
                        default:  op = INVALID;
                    endcase
                end
                `OPC_LOAD: begin
                    case (funct3)
                        `F3_LB:  op = LB;
                        `F3_LH:  op = LH;
                        `F3_LW:  op = LW;
                        `F3_LBU: op = LBU;
                        `F3_LHU: op = LHU;
                        default: op = INVALID;
                    endcase
                end
                `OPC_STORE: begin
                    case (funct3)
                        `F3_SB:  op = SB;
                        `F3_SH:  op = SH;
                        `F3_SW:  op = SW;
                        default: op = INVALID;
                    endcase
                end
                `OPC_OP_IMM: begin
                    case (funct3)
                        `F3_ADD_SUB: op = ADD;
                        `F3_SLT:     op = SLT;
                        `F3_SLTU:    op = SLTU;
                        `F3_XOR:     op = XOR;
                        `F3_OR:      op = OR;
                        `F3_AND:     op = AND;
                        `F3_SLL:     op = (funct7 == `F7_BASE) ? SLL : INVALID;
                        `F3_SR:      op = (funct7 == `F7_BASE) ? SRL :
                                          (funct7 == `F7_ALT)  ? SRA : INVALID;
                    endcase
                end
                `OPC_OP: begin
                    if (funct7 == `F7_BASE) begin
                        case (funct3)
                            `F3_ADD_SUB: op = ADD;
                            `F3_SLL:     op = SLL;
                            `F3_SLT:     op = SLT;
                            `F3_SLTU:    op = SLTU;
                            `F3_XOR:     op = XOR;
                            `F3_SR:      op = SRL;
                            `F3_OR:      op = OR;
                            `F3_AND:     op = AND;
                        endcase
                    end else if (funct7 == `F7_ALT) begin
                        case (funct3)
                            `F3_ADD_SUB: op = SUB;
                            `F3_SR:      op = SRA;
                            default:     op = INVALID;
                        endcase
                    end
                end
                default: op = INVALID;                      // System space and garbage
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Format, by opcode only
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (opcode)
            `OPC_OP_IMM, `OPC_JALR, `OPC_LOAD: fmt = I_TYPE;
            `OPC_STORE:                        fmt = S_TYPE;
            `OPC_BRANCH:                       fmt = B_TYPE;
            `OPC_LUI, `OPC_AUIPC:              fmt = U_TYPE;
            `OPC_JAL:                          fmt = J_TYPE;
            default:                           fmt = R_TYPE;
        endcase
    end

    assign dec.instr    = cur_instr_i;
    assign dec.op       = op;
    assign dec.fmt      = fmt;
    assign dec.rs1      = cur_instr_i[19:15];
    assign dec.rs2      = cur_instr_i[24:20];
    assign dec.rd       = cur_instr_i[11:7];
    assign dec.is_store = (op == SB) || (op == SH) || (op == SW);
    assign dec.is_mem   = (unit_e'(op[5:3]) == MEMORY_UNIT);

endmodule

//--- rtl/operand_issue.sv
`timescale 1ns/100ps

module operand_issue (
    input  logic          clk,
    input  logic          reset,
    input  logic          stall_i,
    input  logic          hazard_i,
    input  rv_pkg::word_t instruction_i,
    input  rv_pkg::word_t pc_i,
    input  rv_pkg::tag_t  tag_i,
    input  rv_pkg::word_t rs1_data_i,
    input  rv_pkg::word_t rs2_data_i,
    input  rv_pkg::word_t imm_i,
    decode_if.issue_view  dec,
    output rv_pkg::word_t cur_instr_o,
    output rv_pkg::word_t operand1_o,
    output rv_pkg::word_t operand2_o,
    output rv_pkg::word_t operand3_o,
    output rv_pkg::word_t pc_o,
    output rv_pkg::tag_t  tag_o,
    output rv_pkg::op_e   op_o,
    output logic          exception_o
);
    import rv_pkg::*;

    word_t last_instr;
    logic  last_hazard;
    word_t operand1;
    word_t operand2;
    word_t operand3;

    ////////////////////////////////////////////////////////////
    // Replay of the word that hit a hazard
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        last_instr <= cur_instr_o;      // Captures every cycle, stall or not
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_hazard <= 1'b0;
        end else begin
            last_hazard <= hazard_i;
        end
    end

    assign cur_instr_o = last_hazard ? last_instr : instruction_i;

    // Operand selection by format
    assign operand1 = (dec.fmt == U_TYPE || dec.fmt == J_TYPE) ? pc_i : rs1_data_i;
    assign operand2 = (dec.fmt == R_TYPE || dec.fmt == B_TYPE) ? rs2_data_i : imm_i;
    assign operand3 = (dec.fmt == S_TYPE) ? rs2_data_i : imm_i;     // Store data

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            operand1_o  <= '0;
            operand2_o  <= '0;
            operand3_o  <= '0;
            pc_o        <= '0;
            tag_o       <= '0;
            op_o        <= NOP;
            exception_o <= 1'b0;
        end else if (stall_i) begin
            operand1_o  <= operand1_o;                      // Hold for downstream
            operand2_o  <= operand2_o;
            operand3_o  <= operand3_o;
            pc_o        <= pc_o;
            tag_o       <= tag_o;
            op_o        <= op_o;
            exception_o <= exception_o;
        end else if (hazard_i) begin
            operand1_o  <= '0;                              // Bubble
            operand2_o  <= '0;
            operand3_o  <= '0;
            pc_o        <= '0;
            tag_o       <= tag_i;
            op_o        <= NOP;
            exception_o <= 1'b0;
        end else begin
            operand1_o  <= operand1;
            operand2_o  <= operand2;
            operand3_o  <= operand3;
            pc_o        <= pc_i;
            tag_o       <= tag_i;
            op_o        <= dec.op;
            exception_o <= (dec.op == INVALID);
        end
    end

endmodule

//--- rtl/reg_lock_queue.sv
`timescale 1ns/100ps

module reg_lock_queue (
    input  logic              clk,
    input  logic              reset,
    input  logic              stall_i,
    decode_if.lock_view       dec,
    output logic              hazard_o,
    output rv_pkg::reg_addr_t rd_o
);
    import rv_pkg::*;

    reg_addr_t lock_reg [2];        // Pending destinations, 0 is youngest
    logic      lock_store [2];      // Pending stores
    logic      mem_block;
    logic      rs1_block;
    logic      rs2_block;

    ////////////////////////////////////////////////////////////
    // Hazard detection
    ////////////////////////////////////////////////////////////

    // Memory ops wait until no store is in flight
    assign mem_block = (lock_store[0] || lock_store[1]) && dec.is_mem;
    assign rs1_block = (dec.rs1 != '0) && (dec.rs1 == lock_reg[0]);
    assign rs2_block = (dec.rs2 != '0) && (dec.rs2 == lock_reg[0]);   // Any format
    assign hazard_o  = mem_block || rs1_block || rs2_block;

    ////////////////////////////////////////////////////////////
    // Queue shift
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            lock_reg[0]   <= '0;
            lock_reg[1]   <= '0;
            lock_store[0] <= 1'b0;
            lock_store[1] <= 1'b0;
        end else if (!stall_i) begin
            lock_reg[1]   <= lock_reg[0];
            lock_store[1] <= lock_store[0];
            if (hazard_o) begin
                lock_reg[0]   <= '0;                        // Bubble locks nothing
                lock_store[0] <= 1'b0;
            end else begin
                lock_reg[0]   <= dec.rd;
                lock_store[0] <= dec.is_store;
            end
        end
    end

    assign rd_o = lock_reg[1];      // Write-back target, two issues back

endmodule

//--- rtl/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Widths
`define XLEN        32
`define REG_ADDR_W  5
`define TAG_W       3

// Major opcodes, instruction bits 6:0
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_BRANCH    7'b1100011
`define OPC_LOAD      7'b0000011
`define OPC_STORE     7'b0100011
`define OPC_OP_IMM    7'b0010011
`define OPC_OP        7'b0110011
`define OPC_MISC_MEM  7'b0001111

// funct3 for the ALU and shift operations
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct3 for jumps, branches, loads, stores and fences
`define F3_JALR     3'b000
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111
`define F3_LB       3'b000
`define F3_LH       3'b001
`define F3_LW       3'b010
`define F3_LBU      3'b100
`define F3_LHU      3'b101
`define F3_SB       3'b000
`define F3_SH       3'b001
`define F3_SW       3'b010
`define F3_FENCE    3'b000

// funct7
`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000

`define NOP_WORD    32'h00000013

`endif

//--- rtl/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`TAG_W-1:0]      tag_t;

    typedef enum logic [2:0] {
        ALU         = 3'b000,
        SHIFT_UNIT  = 3'b001,     // Barrel shifter
        BRANCH_UNIT = 3'b010,
        MEMORY_UNIT = 3'b011,
        NONE        = 3'b111
    } unit_e;

    // Upper three bits select the execution unit
    typedef enum logic [5:0] {
        ADD     = 6'b000_000,
        SUB     = 6'b000_001,
        SLT     = 6'b000_010,
        SLTU    = 6'b000_011,
        XOR     = 6'b000_100,
        OR      = 6'b000_101,
        AND     = 6'b000_110,
        LUI     = 6'b000_111,
        SLL     = 6'b001_000,
        SRL     = 6'b001_001,
        SRA     = 6'b001_010,
        JAL     = 6'b010_000,
        JALR    = 6'b010_001,
        BEQ     = 6'b010_010,
        BNE     = 6'b010_011,
        BLT     = 6'b010_100,
        BGE     = 6'b010_101,
        BLTU    = 6'b010_110,
        BGEU    = 6'b010_111,
        LB      = 6'b011_000,
        LH      = 6'b011_001,
        LW      = 6'b011_010,
        LBU     = 6'b011_011,
        LHU     = 6'b011_100,
        SB      = 6'b011_101,
        SH      = 6'b011_110,
        SW      = 6'b011_111,
        NOP     = 6'b111_000,
        INVALID = 6'b111_111
    } op_e;

    typedef enum logic [2:0] {
        R_TYPE = 3'd0,
        I_TYPE = 3'd1,
        S_TYPE = 3'd2,
        B_TYPE = 3'd3,
        U_TYPE = 3'd4,
        J_TYPE = 3'd5
    } format_e;

endpackage

//--- sim.f
+incdir+rtl
+incdir+test
rtl/rv_pkg.sv
rtl/decode_if.sv
rtl/instr_classifier.sv
rtl/imm_gen.sv
rtl/reg_lock_queue.sv
rtl/operand_issue.sv
rtl/decode_stage.sv
test/decode_properties.sv
test/decode_stage_tb.sv

//--- test/decode_properties.sv
`timescale 1ns/100ps

module decode_properties (
    input logic        clk,
    input logic        reset,
    input logic        stall_i,
    input logic        hazard_o,
    input rv_pkg::op_e op_o
);
    import rv_pkg::*;

    logic bubble;

    assign bubble = hazard_o && !stall_i;       // Bubble goes out on this edge

    // A register hazard clears after one bubble, a store after two
    hazard_limit: assert property (
        @(posedge clk) disable iff (reset)
        !(bubble && $past(bubble) && $past(bubble, 2))
    ) else $error("hazard_o stayed high for three unstalled cycles");

    bubble_is_nop: assert property (
        @(posedge clk) disable iff (reset)
        $past(bubble && !reset) |-> (op_o == NOP)
    ) else $error("op_o is not NOP after a bubble");

endmodule

bind decode_stage decode_properties i_decode_properties (
    .clk      (clk),
    .reset    (reset),
    .stall_i  (stall_i),
    .hazard_o (hazard_o),
    .op_o     (op_o)
);

//--- test/decode_ref.svh
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// ALU operation shared by the OP and OP_IMM opcodes
function automatic op_e alu_op(input logic [2:0] f3);
    case (f3)
        3'd0:    return ADD;
        3'd1:    return SLL;
        3'd2:    return SLT;
        3'd3:    return SLTU;
        3'd4:    return XOR;
        3'd5:    return SRL;
        3'd6:    return OR;
        default: return AND;
    endcase
endfunction

function automatic op_e expected_op(input word_t w);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    opc = w[6:0];
    f3  = w[14:12];
    f7  = w[31:25];
    if (w == 32'h0000_0013) return NOP;                    // Canonical NOP
    case (opc)
        7'h37: return LUI;
        7'h17: return ADD;                                 // AUIPC
        7'h6f: return JAL;
        7'h67: return (f3 == 3'd0) ? JALR : INVALID;
        7'h0f: return (f3 == 3'd0) ? NOP : INVALID;        // FENCE
        7'h63: begin
            case (f3)
                3'd0:    return BEQ;
                3'd1:    return BNE;
                3'd4:    return BLT;
                3'd5:    return BGE;
                3'd6:    return BLTU;
                3'd7:    return BGEU;
                default: return INVALID;
            endcase
        end
        7'h03: begin
            case (f3)
                3'd0:    return LB;
                3'd1:    return LH;
                3'd2:    return LW;
                3'd4:    return LBU;
                3'd5:    return LHU;
                default: return INVALID;
            endcase
        end
        7'h23: return (f3 == 3'd0) ? SB : (f3 == 3'd1) ? SH : (f3 == 3'd2) ? SW : INVALID;
        7'h13: begin
            if (f3 == 3'd1 && f7 != 7'h00) return INVALID;  // Bad shift amount form
            if (f3 == 3'd5) return (f7 == 7'h00) ? SRL : (f7 == 7'h20) ? SRA : INVALID;
            return alu_op(f3);
        end
        7'h33: begin
            if (f7 == 7'h00) return alu_op(f3);
            if (f7 == 7'h20 && f3 == 3'd0) return SUB;
            if (f7 == 7'h20 && f3 == 3'd5) return SRA;
            return INVALID;
        end
        default: return INVALID;                           // System space and garbage
    endcase
endfunction

function automatic format_e expected_fmt(input word_t w);
    case (w[6:0])
        7'h13, 7'h67, 7'h03: return I_TYPE;
        7'h23:               return S_TYPE;
        7'h63:               return B_TYPE;
        7'h37, 7'h17:        return U_TYPE;
        7'h6f:               return J_TYPE;
        default:             return R_TYPE;
    endcase
endfunction

// Fields are packed at the top, then shifted down arithmetically
function automatic word_t expected_imm(input word_t w, input format_e fmt);
    logic signed [31:0] v;
    case (fmt)
        I_TYPE:  v = $signed({w[31:20], 20'b0}) >>> 20;
        S_TYPE:  v = $signed({w[31:25], w[11:7], 20'b0}) >>> 20;
        B_TYPE:  v = $signed({w[31], w[7], w[30:25], w[11:8], 20'b0}) >>> 19;
        U_TYPE:  v = {w[31:12], 12'b0};
        J_TYPE:  v = $signed({w[31], w[19:12], w[20], w[30:21], 12'b0}) >>> 11;
        default: v = 32'sd0;
    endcase
    return v;
endfunction

function automatic word_t expected_operand1(input format_e fmt, input word_t pc,
                                            input word_t rs1_data);
    return (fmt inside {U_TYPE, J_TYPE}) ? pc : rs1_data;
endfunction

function automatic word_t expected_operand2(input format_e fmt, input word_t rs2_data,
                                            input word_t imm);
    return (fmt inside {R_TYPE, B_TYPE}) ? rs2_data : imm;
endfunction

function automatic word_t expected_operand3(input format_e fmt, input word_t rs2_data,
                                            input word_t imm);
    return (fmt == S_TYPE) ? rs2_data : imm;
endfunction

function automatic logic is_mem_op(input op_e op);
    return op inside {LB, LH, LW, LBU, LHU, SB, SH, SW};
endfunction

function automatic logic is_store_op(input op_e op);
    return op inside {SB, SH, SW};
endfunction

`endif

//--- test/decode_stage_tb.sv
`timescale 1ns/100ps

module decode_stage_tb;
    import rv_pkg::*;

    `include "decode_ref.svh"

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_CYCLES   = 3000;
    localparam int NUM_DIRECTED = 8;

    // Dependency chain, store then loads, then dropped system words
    localparam word_t DIRECTED [NUM_DIRECTED] = '{
        32'h0050_0093, 32'h0010_8133, 32'h0021_A023, 32'h0001_A203,
        32'h0041_A283, 32'h0000_0073, 32'h3020_0073, 32'h0000_0013
    };

    logic      clk;
    logic      reset;
    logic      stall_i;
    word_t     instruction_i;
    word_t     pc_i;
    tag_t      tag_i;
    word_t     rs1_data_i;
    word_t     rs2_data_i;
    reg_addr_t rs1_o;
    reg_addr_t rs2_o;
    reg_addr_t rd_o;
    word_t     operand1_o;
    word_t     operand2_o;
    word_t     operand3_o;
    word_t     pc_o;
    tag_t      tag_o;
    op_e       op_o;
    logic      hazard_o;
    logic      exception_o;

    integer    seed;
    int        errors;
    int        cycles_checked;
    logic      hazard_seen;         // Next word on instruction_i is ignored

    // Model of the replay register, lock queue and output register
    word_t     m_last_instr;
    logic      m_last_hazard;
    reg_addr_t m_lock_reg [2];
    logic      m_lock_store [2];
    word_t     e_op1;
    word_t     e_op2;
    word_t     e_op3;
    word_t     e_pc;
    tag_t      e_tag;
    op_e       e_op;
    logic      e_exc;

    decode_stage i_decode_stage (
        .clk           (clk),
        .reset         (reset),
        .stall_i       (stall_i),
        .instruction_i (instruction_i),
        .pc_i          (pc_i),
        .tag_i         (tag_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .rs1_o         (rs1_o),
        .rs2_o         (rs2_o),
        .rd_o          (rd_o),
        .operand1_o    (operand1_o),
        .operand2_o    (operand2_o),
        .operand3_o    (operand3_o),
        .pc_o          (pc_o),
        .tag_o         (tag_o),
        .op_o          (op_o),
        .hazard_o      (hazard_o),
        .exception_o   (exception_o)
    );

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("Error %s: expected %h, actual %h at %0t", name, expected, actual, $time);
    endtask

    // Kept encodings with registers x0..x3, system words and garbage
    function automatic word_t random_word();
        logic [31:0] r;
        logic [31:0] g;
        logic [6:0]  opc;
        word_t       w;
        r = $random(seed);
        g = $random(seed);
        if (r[3:0] == 4'd0) return g;
        if (r[3:0] == 4'd1) begin
            case (g[2:0])
                3'd0:    return 32'h0000_0073;              // ECALL
                3'd1:    return 32'h0010_0073;              // EBREAK
                3'd2:    return 32'h3020_0073;              // MRET
                3'd3:    return 32'h1020_0073;              // SRET
                3'd4:    return 32'h1050_0073;              // WFI
                default: return {g[31:7], 7'h73};           // CSR access
            endcase
        end
        if (r[3:0] == 4'd2) return 32'h0000_0013;
        case (r[7:4])
            4'd0:              opc = 7'h37;
            4'd1:              opc = 7'h17;
            4'd2:              opc = 7'h6f;
            4'd3:              opc = 7'h67;
            4'd4, 4'd5:        opc = 7'h63;
            4'd6, 4'd7, 4'd15: opc = 7'h03;
            4'd8, 4'd9:        opc = 7'h23;
            4'd10, 4'd11:      opc = 7'h13;
            4'd14:             opc = 7'h0f;
            default:           opc = 7'h33;
        endcase
        w = g;
        w[6:0]   = opc;
        w[11:7]  = {3'b000, r[11:10]};
        w[19:15] = {3'b000, r[13:12]};
        w[24:20] = {3'b000, r[15:14]};
        if (!r[16]) w[31:25] = r[17] ? 7'h20 : 7'h00;
        return w;
    endfunction

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        int          dir_idx;
        seed          = 32'hf59d;
        dir_idx       = 0;
        hazard_seen   = 1'b0;
        m_last_hazard = 1'b0;
        reset         = 1'b1;
        stall_i       = 1'b0;
        instruction_i = 32'h0000_0013;
        pc_i          = '0;
        tag_i         = '0;
        rs1_data_i    = '0;
        rs2_data_i    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < NUM_CYCLES; i++) begin
            r = $random(seed);
            if (hazard_seen) begin
                instruction_i <= r;                         // Garbage during replay
            end else if (dir_idx < NUM_DIRECTED) begin
                instruction_i <= DIRECTED[dir_idx];
                dir_idx++;
            end else begin
                instruction_i <= random_word();
            end
            pc_i       <= $random(seed);
            rs1_data_i <= $random(seed);
            rs2_data_i <= $random(seed);
            r = $random(seed);
            tag_i   <= r[2:0];
            stall_i <= (dir_idx >= NUM_DIRECTED) && (r[6:4] == 3'd0);
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        $display("Cycles checked: %0d, errors: %0d", cycles_checked, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Model and compare, on the falling edge
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        word_t   cur;
        op_e     op;
        format_e fmt;
        word_t   imm;
        logic    hz;
        cur = m_last_hazard ? m_last_instr : instruction_i;
        op  = expected_op(cur);
        fmt = expected_fmt(cur);
        imm = expected_imm(cur, fmt);
        hz  = ((m_lock_store[0] || m_lock_store[1]) && is_mem_op(op))
              || (cur[19:15] != 5'd0 && cur[19:15] == m_lock_reg[0])
              || (cur[24:20] != 5'd0 && cur[24:20] == m_lock_reg[0]);

        if (!reset) begin
            cycles_checked++;
            if (op_o !== e_op) report_mismatch("op_o", 32'(e_op), 32'(op_o));
            if (exception_o !== e_exc) report_mismatch("exception_o", 32'(e_exc), 32'(exception_o));
            if (operand1_o !== e_op1) report_mismatch("operand1_o", e_op1, operand1_o);
            if (operand2_o !== e_op2) report_mismatch("operand2_o", e_op2, operand2_o);
            if (operand3_o !== e_op3) report_mismatch("operand3_o", e_op3, operand3_o);
            if (pc_o !== e_pc) report_mismatch("pc_o", e_pc, pc_o);
            if (tag_o !== e_tag) report_mismatch("tag_o", 32'(e_tag), 32'(tag_o));
            if (rd_o !== m_lock_reg[1]) report_mismatch("rd_o", 32'(m_lock_reg[1]), 32'(rd_o));
            if (rs1_o !== cur[19:15]) report_mismatch("rs1_o", 32'(cur[19:15]), 32'(rs1_o));
            if (rs2_o !== cur[24:20]) report_mismatch("rs2_o", 32'(cur[24:20]), 32'(rs2_o));
            if (hazard_o !== hz) report_mismatch("hazard_o", 32'(hz), 32'(hazard_o));
        end

        // State after the coming rising edge
        m_last_instr = cur;
        if (reset) begin
            m_last_hazard   = 1'b0;
            m_lock_reg[0]   = '0;
            m_lock_reg[1]   = '0;
            m_lock_store[0] = 1'b0;
            m_lock_store[1] = 1'b0;
            {e_op1, e_op2, e_op3, e_pc} = '0;
            e_tag = '0;
            e_op  = NOP;
            e_exc = 1'b0;
        end else begin
            m_last_hazard = hz;
            if (!stall_i) begin
                m_lock_reg[1]   = m_lock_reg[0];
                m_lock_store[1] = m_lock_store[0];
                m_lock_reg[0]   = hz ? 5'd0 : cur[11:7];
                m_lock_store[0] = hz ? 1'b0 : is_store_op(op);
                e_tag = tag_i;
                if (hz) begin
                    {e_op1, e_op2, e_op3, e_pc} = '0;
                    e_op  = NOP;
                    e_exc = 1'b0;
                end else begin
                    e_op1 = expected_operand1(fmt, pc_i, rs1_data_i);
                    e_op2 = expected_operand2(fmt, rs2_data_i, imm);
                    e_op3 = expected_operand3(fmt, rs2_data_i, imm);
                    e_pc  = pc_i;
                    e_op  = op;
                    e_exc = (op == INVALID);
                end
            end
        end
        hazard_seen = !reset && hz;
    end

    // Watchdog
    initial begin
        #((RESET_CYCLES + NUM_CYCLES + 100) * CLK_PERIOD);
        $display("Timeout: the stimulus did not finish in the expected time");
        $display("Cycles checked: %0d, errors: %0d", cycles_checked, errors);
        $display("** FAIL **");
        $finish;
    end

endmodule
